// ==== sim.f ====
design/midi_pkg.sv
design/midi_byte_capture.sv
design/voice_allocator.sv
design/midi_ctrl_decode.sv
design/midi_decoder.sv
verification/tb_clock_gen.sv
verification/tb_midi_decoder.sv

// ==== Makefile ====
TOP := tb_midi_decoder

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -sv -Wno-fatal -f sim.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/tb_midi_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_midi_decoder;
    import midi_pkg::*;

    localparam int VOICES     = 8;
    localparam int DRAIN      = 4;      // covers the 2 cycle latency plus margin
    localparam int LEN_T1     = 8;
    localparam int LEN_T2     = 12 * 4 * 2 + DRAIN;
    localparam int LEN_T3     = 10 * 2 * 2 + DRAIN;
    localparam int LEN_T4     = 8 * 2 * 2 + DRAIN;
    localparam int LEN_T5     = 2 * 2 + DRAIN;
    localparam int LEN_T6     = 24 * 2 * 2 + DRAIN;
    localparam int MAX_CYCLES = 2 * (LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5 + LEN_T6) + 4;

    logic CLOCK_25;
    logic iRST_N;
    logic byteready;
    logic [7:0] cur_status;
    logic [7:0] midibyte_nr;
    logic [7:0] midibyte;
    logic [3:0] midi_ch;
    logic [VOICES-1:0] voice_free;
    logic [VOICES-1:0] keys_on;
    logic note_on;
    logic [2:0] cur_key_adr;
    logic [7:0] cur_key_val;
    logic [7:0] cur_vel_on;
    logic [7:0] cur_vel_off;
    logic [3:0] active_keys;
    logic off_note_error;
    logic prg_ch_cmd;
    logic [7:0] prg_ch_data;
    logic octrl_cmd;
    logic [7:0] octrl;
    logic [7:0] octrl_data;
    logic pitch_cmd;
    logic [7:0] pitch_lsb;
    logic [7:0] pitch_msb;

    // model of the decoder
    logic [7:0] m_key [VOICES];
    logic [VOICES-1:0] m_on;
    int m_age [$];                      // sounding voices, oldest first
    int m_cnt;
    int m_target;
    int m_adr;
    logic [7:0] m_pend;
    logic [7:0] m_val;
    logic [7:0] m_vel_on;
    logic [7:0] m_vel_off;
    logic m_err;
    logic m_note_on;
    logic m_prg_cmd;
    logic m_octrl_cmd;
    logic m_pitch_cmd;
    logic [7:0] m_prg;
    logic [7:0] m_octrl;
    logic [7:0] m_octrl_data;
    logic [7:0] m_lsb;
    logic [7:0] m_msb;

    logic [36:0] pipe [2];              // {byteready, status, nr, data, ch, voice_free}
    logic [31:0] rng;
    logic [7:0] next_free;
    logic [3:0] chan;
    logic checking = 1'b0;
    int cmp_errors = 0;
    int step_errors = 0;
    int errs_before = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;

    tb_clock_gen u_tb_clock_gen (
        .CLOCK_25 (CLOCK_25),
        .iRST_N   (iRST_N)
    );

    midi_decoder #(
        .VOICES (VOICES)
    ) u_midi_decoder (
        .CLOCK_25       (CLOCK_25),
        .iRST_N         (iRST_N),
        .byteready      (byteready),
        .cur_status     (cur_status),
        .midibyte_nr    (midibyte_nr),
        .midibyte       (midibyte),
        .midi_ch        (midi_ch),
        .voice_free     (voice_free),
        .keys_on        (keys_on),
        .note_on        (note_on),
        .cur_key_adr    (cur_key_adr),
        .cur_key_val    (cur_key_val),
        .cur_vel_on     (cur_vel_on),
        .cur_vel_off    (cur_vel_off),
        .active_keys    (active_keys),
        .off_note_error (off_note_error),
        .prg_ch_cmd     (prg_ch_cmd),
        .prg_ch_data    (prg_ch_data),
        .octrl_cmd      (octrl_cmd),
        .octrl          (octrl),
        .octrl_data     (octrl_data),
        .pitch_cmd      (pitch_cmd),
        .pitch_lsb      (pitch_lsb),
        .pitch_msb      (pitch_msb)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic int lowest_voice(input logic [VOICES-1:0] mask);
        int v;
        v = -1;
        for (int i = VOICES - 1; i >= 0; i--) begin
            if (mask[i]) v = i;
        end
        return v;
    endfunction

    function automatic void drop_from_age(input int v);
        for (int i = m_age.size() - 1; i >= 0; i--) begin
            if (m_age[i] == v) m_age.delete(i);
        end
    endfunction

    function automatic void clear_voices();
        for (int i = 0; i < VOICES; i++) m_key[i] = KEY_EMPTY;
        m_on = '0;
        m_age.delete();
        m_cnt = 0;
        m_err = 1'b0;
    endfunction

    function automatic void clear_model();
        clear_voices();
        {m_target, m_adr} = '0;
        {m_pend, m_val} = {KEY_EMPTY, KEY_EMPTY};
        {m_vel_on, m_vel_off, m_prg, m_octrl, m_octrl_data, m_lsb, m_msb} = '0;
        {m_note_on, m_prg_cmd, m_octrl_cmd, m_pitch_cmd} = '0;
    endfunction

    // one accepted byte through the voice and controller rules
    function automatic void model_event(input logic [36:0] b);
        logic [7:0] st;
        logic [7:0] nr;
        logic [7:0] d;
        logic [3:0] ch;
        logic [7:0] vf;
        logic first;
        int v;
        {st, nr, d, ch, vf} = b[35:0];
        first = (nr == 8'd1);
        if (st[3:0] != ch || !(nr == 8'd1 || nr == 8'd2)) return;
        case (st[7:4])
            ST_NOTE_ON: begin
                if (first) begin
                    m_pend = d;
                    if (m_cnt == VOICES) begin
                        v = m_age.pop_front();          // steal oldest
                        m_on[v] = 1'b0;
                        m_key[v] = KEY_EMPTY;
                        m_cnt--;
                    end else begin
                        v = lowest_voice(vf & ~m_on);
                        if (v < 0) v = lowest_voice(~m_on);
                    end
                    m_target = v;
                end else begin
                    m_on[m_target] = 1'b1;
                    m_key[m_target] = m_pend;
                    m_age.push_back(m_target);
                    m_cnt++;
                    m_adr = m_target;
                    m_val = m_pend;
                    m_vel_on = d;
                    m_note_on = 1'b1;
                end
            end
            ST_NOTE_OFF: begin
                if (first) begin
                    v = -1;
                    for (int i = VOICES - 1; i >= 0; i--) begin
                        if (m_on[i] && m_key[i] == d) v = i;
                    end
                    if (v >= 0) begin
                        m_on[v] = 1'b0;
                        m_key[v] = KEY_EMPTY;
                        drop_from_age(v);
                        m_cnt--;
                        m_adr = v;
                        m_val = KEY_EMPTY;
                    end else begin
                        m_err = 1'b1;
                    end
                end else begin
                    m_vel_off = d;
                end
            end
            ST_CTRL: begin
                if (first) begin
                    m_octrl = d;
                    if (d == CC_ALL_NOTES_OFF) clear_voices();
                end else begin
                    m_octrl_data = d;
                    m_octrl_cmd = 1'b1;
                end
            end
            ST_PRG_CHANGE: begin
                if (first) begin
                    m_prg = d;
                    m_prg_cmd = 1'b1;
                end
            end
            ST_PITCH: begin
                if (first) m_lsb = d;
                else begin
                    m_msb = d;
                    m_pitch_cmd = 1'b1;
                end
            end
            default: ;
        endcase
    endfunction

    function automatic logic differs(input string name, input logic [31:0] got,
                                     input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic compare_outputs();
        if (differs("keys_on", 32'(keys_on), 32'(m_on))) cmp_errors++;
        if (differs("note_on", 32'(note_on), 32'(m_note_on))) cmp_errors++;
        if (differs("cur_key_adr", 32'(cur_key_adr), 32'(m_adr))) cmp_errors++;
        if (differs("cur_key_val", 32'(cur_key_val), 32'(m_val))) cmp_errors++;
        if (differs("cur_vel_on", 32'(cur_vel_on), 32'(m_vel_on))) cmp_errors++;
        if (differs("cur_vel_off", 32'(cur_vel_off), 32'(m_vel_off))) cmp_errors++;
        if (differs("active_keys", 32'(active_keys), 32'(m_cnt))) cmp_errors++;
        if (differs("off_note_error", 32'(off_note_error), 32'(m_err))) cmp_errors++;
        if (differs("prg_ch_cmd", 32'(prg_ch_cmd), 32'(m_prg_cmd))) cmp_errors++;
        if (differs("prg_ch_data", 32'(prg_ch_data), 32'(m_prg))) cmp_errors++;
        if (differs("octrl_cmd", 32'(octrl_cmd), 32'(m_octrl_cmd))) cmp_errors++;
        if (differs("octrl", 32'(octrl), 32'(m_octrl))) cmp_errors++;
        if (differs("octrl_data", 32'(octrl_data), 32'(m_octrl_data))) cmp_errors++;
        if (differs("pitch_cmd", 32'(pitch_cmd), 32'(m_pitch_cmd))) cmp_errors++;
        if (differs("pitch_lsb", 32'(pitch_lsb), 32'(m_lsb))) cmp_errors++;
        if (differs("pitch_msb", 32'(pitch_msb), 32'(m_msb))) cmp_errors++;
    endtask

    // bytes sampled by the DUT, aligned to their 2 cycle result
    always @(posedge CLOCK_25) begin
        if (!iRST_N) begin
            pipe[0] <= '0;
            pipe[1] <= '0;
        end else begin
            pipe[0] <= {byteready, cur_status, midibyte_nr, midibyte, midi_ch, voice_free};
            pipe[1] <= pipe[0];
        end
    end

    always @(negedge CLOCK_25) begin
        if (!iRST_N) begin
            clear_model();
        end else begin
            {m_note_on, m_prg_cmd, m_octrl_cmd, m_pitch_cmd} = '0;   // strobes idle
            if (pipe[1][36]) model_event(pipe[1]);
            if (checking) compare_outputs();
        end
    end

    always @(posedge CLOCK_25) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped by the cycle limit after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic send_byte(input logic [7:0] st, input logic [7:0] nr, input logic [7:0] d);
        @(posedge CLOCK_25);
        byteready <= 1'b1;
        cur_status <= st;
        midibyte_nr <= nr;
        midibyte <= d;
        voice_free <= next_free;
        @(posedge CLOCK_25);
        byteready <= 1'b0;          // idle cycle follows
    endtask

    task automatic send_msg(input logic [7:0] st, input logic [7:0] d1, input logic [7:0] d2);
        send_byte(st, 8'd1, d1);
        send_byte(st, 8'd2, d2);
    endtask

    task automatic settle();
        repeat (DRAIN) @(posedge CLOCK_25);
        @(negedge CLOCK_25);
    endtask

    task automatic finish_test(input string name);
        int errs;
        @(posedge CLOCK_25);
        errs = cmp_errors + step_errors - errs_before;
        if (errs == 0) begin
            $display("test %-16s ok", name);
        end else begin
            $display("test %-16s FAILED with %0d errors", name, errs);
            tests_failed++;
        end
        tests_run++;
        errs_before = cmp_errors + step_errors;
    endtask

    initial begin
        logic [31:0] r;
        rng = 32'hbb82_2ce6;
        chan = 4'h5;
        next_free = '1;
        byteready = 1'b0;
        cur_status = '0;
        midibyte_nr = '0;
        midibyte = '0;
        midi_ch = chan;
        voice_free = '1;

        wait (iRST_N === 1'b1);
        @(negedge CLOCK_25);
        checking = 1'b1;
        repeat (LEN_T1) @(posedge CLOCK_25);
        finish_test("reset_state");

        for (int i = 0; i < 12; i++) begin
            r = next_rand();
            next_free = r[7:0];
            send_msg({ST_NOTE_ON, chan}, {1'b0, r[14:8]}, {1'b0, r[22:16]});
            send_msg({ST_NOTE_ON, chan ^ 4'h2}, {1'b0, r[30:24]}, 8'h40);   // ignored
        end
        settle();
        finish_test("note_on_alloc");

        next_free = '1;
        send_msg({ST_CTRL, chan}, CC_ALL_NOTES_OFF, 8'h00);
        for (int i = 0; i < 9; i++) begin
            send_msg({ST_NOTE_ON, chan}, 8'h30 + 8'(i), 8'h50 + 8'(i));
        end
        settle();
        if (differs("cur_key_adr", 32'(cur_key_adr), 32'd0)) step_errors++;
        if (differs("active_keys", 32'(active_keys), 32'd8)) step_errors++;
        finish_test("voice_steal");

        send_msg({ST_NOTE_OFF, chan}, 8'h38, 8'h21);
        send_msg({ST_NOTE_OFF, chan}, 8'h33, 8'h22);
        send_msg({ST_NOTE_OFF, chan}, 8'h30, 8'h23);   // stolen earlier
        for (int i = 0; i < 4; i++) begin
            r = next_rand();
            send_msg({ST_NOTE_OFF, chan}, {4'h3, r[3:0]}, {1'b0, r[14:8]});
        end
        send_msg({ST_NOTE_OFF, chan}, 8'h7F, 8'h10);
        settle();
        if (differs("off_note_error", 32'(off_note_error), 32'd1)) step_errors++;
        finish_test("note_off");

        r = next_rand();
        send_msg({ST_CTRL, chan}, CC_ALL_NOTES_OFF, {1'b0, r[6:0]});
        settle();
        if (differs("keys_on", 32'(keys_on), 32'd0)) step_errors++;
        if (differs("active_keys", 32'(active_keys), 32'd0)) step_errors++;
        if (differs("off_note_error", 32'(off_note_error), 32'd0)) step_errors++;
        if (differs("octrl", 32'(octrl), 32'h7B)) step_errors++;
        finish_test("all_notes_off");

        for (int i = 0; i < 24; i++) begin
            r = next_rand();
            midi_ch <= (r[20:18] == 3'd0) ? chan ^ 4'h8 : chan;     // some misses
            case (r[1:0])
                2'd0: send_byte({ST_PRG_CHANGE, chan}, 8'd1, {1'b0, r[14:8]});
                2'd1: send_msg({ST_CTRL, chan}, {1'b0, r[14:8]}, {1'b0, r[30:24]});
                2'd2: send_msg({ST_PITCH, chan}, {1'b0, r[14:8]}, {1'b0, r[30:24]});
                default: send_msg({4'hA, chan}, {1'b0, r[14:8]}, 8'h11);
            endcase
        end
        settle();
        finish_test("controllers");

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, cmp_errors + step_errors);
        if (tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_midi_decoder

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_NS    = 2,   // 4 ns period
    parameter int RST_CYCLES = 4
) (
    output logic CLOCK_25,
    output logic iRST_N
);

    initial begin
        CLOCK_25 = 1'b0;
        forever #HALF_NS CLOCK_25 = ~CLOCK_25;
    end

    // reset held over the first rising edges
    initial begin
        iRST_N = 1'b0;
        repeat (RST_CYCLES) @(posedge CLOCK_25);
        iRST_N <= 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

// ==== design/midi_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module midi_decoder #(
    parameter  int VOICES  = 8,
    localparam int V_WIDTH = $clog2(VOICES)
) (
    input  wire                   CLOCK_25,
    input  wire                   iRST_N,
    // framed bytes from the uart
    input  wire                   byteready,
    input  wire midi_pkg::midi_byte_t cur_status,
    input  wire midi_pkg::midi_byte_t midibyte_nr,
    input  wire midi_pkg::midi_byte_t midibyte,
    input  wire [3:0]             midi_ch,
    input  wire [VOICES-1:0]      voice_free,
    // note side
    output logic [VOICES-1:0]     keys_on,
    output logic                  note_on,
    output logic [V_WIDTH-1:0]    cur_key_adr,
    output midi_pkg::midi_byte_t  cur_key_val,
    output midi_pkg::midi_byte_t  cur_vel_on,
    output midi_pkg::midi_byte_t  cur_vel_off,
    output logic [V_WIDTH:0]      active_keys,
    output logic                  off_note_error,
    // controller side
    output logic                  prg_ch_cmd,
    output midi_pkg::midi_byte_t  prg_ch_data,
    output logic                  octrl_cmd,
    output midi_pkg::midi_byte_t  octrl,
    output midi_pkg::midi_byte_t  octrl_data,
    output logic                  pitch_cmd,
    output midi_pkg::midi_byte_t  pitch_lsb,
    output midi_pkg::midi_byte_t  pitch_msb
);
    import midi_pkg::*;

    // decoded event shared by both decoders
    logic       ev_valid;
    logic [3:0] ev_status;
    logic       ev_first;
    midi_byte_t ev_data;

    midi_byte_capture u_midi_byte_capture (
        .CLOCK_25    (CLOCK_25),
        .iRST_N      (iRST_N),
        .byteready   (byteready),
        .cur_status  (cur_status),
        .midibyte_nr (midibyte_nr),
        .midibyte    (midibyte),
        .midi_ch     (midi_ch),
        .ev_valid    (ev_valid),
        .ev_status   (ev_status),
        .ev_first    (ev_first),
        .ev_data     (ev_data)
    );

    voice_allocator #(
        .VOICES (VOICES)
    ) u_voice_allocator (
        .CLOCK_25       (CLOCK_25),
        .iRST_N         (iRST_N),
        .ev_valid       (ev_valid),
        .ev_status      (ev_status),
        .ev_first       (ev_first),
        .ev_data        (ev_data),
        .voice_free     (voice_free),
        .keys_on        (keys_on),
        .note_on        (note_on),
        .cur_key_adr    (cur_key_adr),
        .cur_key_val    (cur_key_val),
        .cur_vel_on     (cur_vel_on),
        .cur_vel_off    (cur_vel_off),
        .active_keys    (active_keys),
        .off_note_error (off_note_error)
    );

    midi_ctrl_decode u_midi_ctrl_decode (
        .CLOCK_25    (CLOCK_25),
        .iRST_N      (iRST_N),
        .ev_valid    (ev_valid),
        .ev_status   (ev_status),
        .ev_first    (ev_first),
        .ev_data     (ev_data),
        .prg_ch_cmd  (prg_ch_cmd),
        .prg_ch_data (prg_ch_data),
        .octrl_cmd   (octrl_cmd),
        .octrl       (octrl),
        .octrl_data  (octrl_data),
        .pitch_cmd   (pitch_cmd),
        .pitch_lsb   (pitch_lsb),
        .pitch_msb   (pitch_msb)
    );

endmodule : midi_decoder

`default_nettype wire

// ==== design/midi_ctrl_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module midi_ctrl_decode (
    input  wire                   CLOCK_25,
    input  wire                   iRST_N,
    input  wire                   ev_valid,
    input  wire [3:0]             ev_status,
    input  wire                   ev_first,
    input  wire midi_pkg::midi_byte_t ev_data,
    output logic                  prg_ch_cmd,
    output midi_pkg::midi_byte_t  prg_ch_data,
    output logic                  octrl_cmd,
    output midi_pkg::midi_byte_t  octrl,
    output midi_pkg::midi_byte_t  octrl_data,
    output logic                  pitch_cmd,
    output midi_pkg::midi_byte_t  pitch_lsb,
    output midi_pkg::midi_byte_t  pitch_msb
);
    import midi_pkg::*;

    always_ff @(posedge CLOCK_25) begin
        if (!iRST_N) begin
            prg_ch_cmd  <= 1'b0;
            prg_ch_data <= '0;
            octrl_cmd   <= 1'b0;
            octrl       <= '0;
            octrl_data  <= '0;
            pitch_cmd   <= 1'b0;
            pitch_lsb   <= '0;
            pitch_msb   <= '0;
        end else begin
            prg_ch_cmd <= 1'b0;
            octrl_cmd  <= 1'b0;
            pitch_cmd  <= 1'b0;
            if (ev_valid) begin
                case (ev_status)
                    ST_PRG_CHANGE: begin
                        if (ev_first) begin     // single data byte message
                            prg_ch_data <= ev_data;
                            prg_ch_cmd  <= 1'b1;
                        end
                    end
                    ST_CTRL: begin
                        if (ev_first) begin
                            octrl <= ev_data;   // controller number
                        end else begin
                            octrl_data <= ev_data;
                            octrl_cmd  <= 1'b1;
                        end
                    end
                    ST_PITCH: begin
                        if (ev_first) begin
                            pitch_lsb <= ev_data;
                        end else begin
                            pitch_msb <= ev_data;
                            pitch_cmd <= 1'b1;  // fires once both halves are in
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule : midi_ctrl_decode

`default_nettype wire

// ==== design/voice_allocator.sv ====
`timescale 1ns/1ps
`default_nettype none

module voice_allocator #(
    parameter  int VOICES  = 8,
    localparam int V_WIDTH = $clog2(VOICES)
) (
    input  wire                   CLOCK_25,
    input  wire                   iRST_N,
    input  wire                   ev_valid,
    input  wire [3:0]             ev_status,
    input  wire                   ev_first,
    input  wire midi_pkg::midi_byte_t ev_data,
    input  wire [VOICES-1:0]      voice_free,   // from synth engine
    output logic [VOICES-1:0]     keys_on,
    output logic                  note_on,
    output logic [V_WIDTH-1:0]    cur_key_adr,
    output midi_pkg::midi_byte_t  cur_key_val,
    output midi_pkg::midi_byte_t  cur_vel_on,
    output midi_pkg::midi_byte_t  cur_vel_off,
    output logic [V_WIDTH:0]      active_keys,
    output logic                  off_note_error
);
    import midi_pkg::*;

    localparam logic [V_WIDTH:0] FULL_COUNT = (V_WIDTH+1)'(VOICES);

    midi_byte_t         key_val [VOICES];   // key held by each voice
    logic [V_WIDTH-1:0] age_q   [VOICES];   // sounding voices, oldest at 0
    midi_byte_t         pend_key;           // key waiting for its velocity
    logic [V_WIDTH-1:0] target;             // voice picked on the first byte

    logic               free_hit;
    logic [V_WIDTH-1:0] free_idx;
    logic [V_WIDTH-1:0] idle_idx;
    logic               off_hit;
    logic [V_WIDTH-1:0] off_idx;
    logic [V_WIDTH-1:0] off_pos;

    logic on_first;
    logic on_second;
    logic off_first;
    logic off_second;
    logic all_off;
    logic steal;
    logic on_push;
    logic off_rel;

    // decoded events
    assign on_first   = ev_valid && (ev_status == ST_NOTE_ON) && ev_first;
    assign on_second  = ev_valid && (ev_status == ST_NOTE_ON) && !ev_first;
    assign off_first  = ev_valid && (ev_status == ST_NOTE_OFF) && ev_first;
    assign off_second = ev_valid && (ev_status == ST_NOTE_OFF) && !ev_first;
    assign all_off    = ev_valid && (ev_status == ST_CTRL) && ev_first
                        && (ev_data == CC_ALL_NOTES_OFF);

    assign steal   = on_first && (active_keys == FULL_COUNT);
    assign on_push = on_second && !keys_on[target];   // no double count
    assign off_rel = off_first && off_hit;

    // priority searches, loops run downward so the lowest index wins
    always_comb begin
        free_hit = 1'b0;
        free_idx = '0;
        idle_idx = '0;
        off_hit  = 1'b0;
        off_idx  = '0;
        off_pos  = '0;
        for (int v = VOICES - 1; v >= 0; v--) begin
            if (voice_free[v] && !keys_on[v]) begin
                free_hit = 1'b1;
                free_idx = V_WIDTH'(v);
            end
            if (!keys_on[v]) begin
                idle_idx = V_WIDTH'(v);     // fallback when engine reports none free
            end
            if (keys_on[v] && (key_val[v] == ev_data)) begin
                off_hit = 1'b1;
                off_idx = V_WIDTH'(v);
            end
        end
        // queue slot of the voice being released
        for (int i = VOICES - 1; i >= 0; i--) begin
            if (((V_WIDTH+1)'(i) < active_keys) && (age_q[i] == off_idx)) begin
                off_pos = V_WIDTH'(i);
            end
        end
    end

    // key table and age queue
    always_ff @(posedge CLOCK_25) begin
        if (steal) begin
            key_val[age_q[0]] <= KEY_EMPTY;
            for (int i = 0; i < VOICES - 1; i++) begin
                age_q[i] <= age_q[i+1];     // drop the oldest
            end
        end
        if (on_second) begin
            key_val[target] <= pend_key;
        end
        if (on_push) begin
            age_q[active_keys[V_WIDTH-1:0]] <= target;  // newest at the tail
        end
        if (off_rel) begin
            key_val[off_idx] <= KEY_EMPTY;
            for (int i = 0; i < VOICES - 1; i++) begin
                if (V_WIDTH'(i) >= off_pos) begin
                    age_q[i] <= age_q[i+1];
                end
            end
        end
        if (all_off) begin
            for (int v = 0; v < VOICES; v++) begin
                key_val[v] <= KEY_EMPTY;
            end
        end
    end

    always_ff @(posedge CLOCK_25) begin
        if (!iRST_N) begin
            keys_on        <= '0;
            note_on        <= 1'b0;
            cur_key_adr    <= '0;
            cur_key_val    <= KEY_EMPTY;
            cur_vel_on     <= '0;
            cur_vel_off    <= '0;
            active_keys    <= '0;
            off_note_error <= 1'b0;
            pend_key       <= KEY_EMPTY;
            target         <= '0;
        end else begin
            note_on <= 1'b0;
            if (on_first) begin
                pend_key <= ev_data;
                if (steal) begin
                    keys_on[age_q[0]] <= 1'b0;
                    active_keys       <= active_keys - 1'b1;
                    target            <= age_q[0];
                end else if (free_hit) begin
                    target <= free_idx;
                end else begin
                    target <= idle_idx;
                end
            end
            if (on_second) begin
                keys_on[target] <= 1'b1;
                if (on_push) begin
                    active_keys <= active_keys + 1'b1;
                end
                cur_key_adr <= target;
                cur_key_val <= pend_key;
                cur_vel_on  <= ev_data;     // velocity
                note_on     <= 1'b1;
            end
            if (off_first) begin
                if (off_hit) begin
                    keys_on[off_idx] <= 1'b0;
                    active_keys      <= active_keys - 1'b1;
                    cur_key_adr      <= off_idx;
                    cur_key_val      <= KEY_EMPTY;
                end else begin
                    off_note_error <= 1'b1;     // sticky until all notes off
                end
            end
            if (off_second) begin
                cur_vel_off <= ev_data;
            end
            if (all_off) begin
                keys_on        <= '0;
                active_keys    <= '0;
                off_note_error <= 1'b0;
            end
        end
    end

endmodule : voice_allocator

`default_nettype wire

// ==== design/midi_byte_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module midi_byte_capture (
    input  wire                   CLOCK_25,
    input  wire                   iRST_N,
    input  wire                   byteready,    // one cycle per framed byte
    input  wire midi_pkg::midi_byte_t cur_status,
    input  wire midi_pkg::midi_byte_t midibyte_nr,
    input  wire midi_pkg::midi_byte_t midibyte,
    input  wire [3:0]             midi_ch,
    output logic                  ev_valid,
    output logic [3:0]            ev_status,
    output logic                  ev_first,
    output midi_pkg::midi_byte_t  ev_data
);
    import midi_pkg::*;

    logic [3:0] st_nib;
    logic       ch_match;
    logic       st_kept;
    logic       nr_first;
    logic       nr_second;
    logic       accept;

    assign st_nib    = cur_status[7:4];
    assign ch_match  = (cur_status[3:0] == midi_ch);
    assign nr_first  = (midibyte_nr == 8'd1);
    assign nr_second = (midibyte_nr == 8'd2);

    // channel messages this decoder cares about
    always_comb begin
        case (st_nib)
            ST_NOTE_OFF,
            ST_NOTE_ON,
            ST_CTRL,
            ST_PRG_CHANGE,
            ST_PITCH: st_kept = 1'b1;
            default:  st_kept = 1'b0;
        endcase
    end

    // only the two data bytes of a matching message go on
    assign accept = byteready && ch_match && st_kept && (nr_first || nr_second);

    always_ff @(posedge CLOCK_25) begin
        if (!iRST_N) begin
            ev_valid <= 1'b0;
        end else begin
            ev_valid <= accept;     // strobe, one cycle after byteready
        end
    end

    // event payload, qualified by ev_valid downstream
    always_ff @(posedge CLOCK_25) begin
        if (accept) begin
            ev_status <= st_nib;
            ev_first  <= nr_first;  // second byte otherwise
            ev_data   <= midibyte;
        end
    end

endmodule : midi_byte_capture

`default_nettype wire

// ==== design/midi_pkg.sv ====
`default_nettype none

package midi_pkg;

    // one byte on the MIDI stream
    typedef logic [7:0] midi_byte_t;

    // channel message status, high nibble only
    localparam logic [3:0] ST_NOTE_OFF   = 4'h8;
    localparam logic [3:0] ST_NOTE_ON    = 4'h9;
    localparam logic [3:0] ST_CTRL       = 4'hB;
    localparam logic [3:0] ST_PRG_CHANGE = 4'hC;
    localparam logic [3:0] ST_PITCH      = 4'hE;

    // controller numbers handled by the voice logic
    localparam midi_byte_t CC_ALL_NOTES_OFF = 8'h7B;

    // idle voice marker, never a valid 7-bit key
    localparam midi_byte_t KEY_EMPTY = 8'hFF;

endpackage : midi_pkg

`default_nettype wire
